// File: project.f
common/rvv_pkg.sv
logic/insn_decoder.sv
logic/issue_ctrl.sv
logic/cfg_unit.sv
logic/vec_regfile.sv
valu/operand_mux.sv
valu/simd_alu.sv
logic/rvv_core.sv
testbench/rvv_core_tb.sv

// File: Bender.yml
package:
  name: rvv_core

sources:
  - common/rvv_pkg.sv
  - logic/insn_decoder.sv
  - logic/issue_ctrl.sv
  - logic/cfg_unit.sv
  - logic/vec_regfile.sv
  - valu/operand_mux.sv
  - valu/simd_alu.sv
  - logic/rvv_core.sv
  - target: test
    files:
      - testbench/rvv_core_tb.sv

// File: testbench/rvv_core_tb.sv
`timescale 1ns/100ps

module rvv_core_tb;
    import rvv_pkg::*;

    logic            clk;
    logic            rst_n;
    insn_u           insn_in;
    logic            insn_valid;
    logic [xlen-1:0] scalar_in;
    logic            proc_rdy;
    logic            mem_valid;
    store_t          mem_out;
    logic            scalar_valid;
    logic [xlen-1:0] scalar_out;

    logic [data_w-1:0] model_regs [num_vec];   // reference copy of v0..v31
    logic [xlen-1:0]   model_vl;
    sew_e              model_sew;
    store_t            exp_store [$];
    logic [xlen-1:0]   exp_vl [$];
    int                errors;
    int                checks;
    int                n_exp;                  // stores and vsetvli sent
    int                n_got;                  // results seen on the ports
    int                err0;
    int                exp0;
    int                got0;
    integer            seed;

    rvv_core rvv_core_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [63:0] lane_mask(int ew);
        return (ew == 64) ? '1 : (64'd1 << ew) - 64'd1;
    endfunction

    // vs2 op a in each lane, wrapping at the lane width
    function automatic logic [63:0] ref_alu(alu_op_e op, sew_e s, logic [63:0] a,
                                            logic [63:0] b);
        int          ew;
        int          i;
        logic [63:0] m;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] lr;
        logic [63:0] r;
        ew = 8 << s;
        m  = lane_mask(ew);
        r  = '0;
        for (i = 0; i < 64 / ew; i++) begin
            la = (a >> (i * ew)) & m;
            lb = (b >> (i * ew)) & m;
            case (op)
                alu_add: lr = lb + la;
                alu_sub: lr = lb - la;
                alu_and: lr = lb & la;
                alu_or:  lr = lb | la;
                default: lr = lb ^ la;
            endcase
            r = r | ((lr & m) << (i * ew));
        end
        return r;
    endfunction

    function automatic logic [63:0] ref_splat(sew_e s, logic [63:0] x);
        int          ew;
        int          i;
        logic [63:0] r;
        ew = 8 << s;
        r  = '0;
        for (i = 0; i < 64 / ew; i++)
            r = r | ((x & lane_mask(ew)) << (i * ew));   // low lane bits copied up
        return r;
    endfunction

    function automatic logic [31:0] ref_vl(bit rs1_nz, bit rd_nz, logic [31:0] avl, sew_e s,
                                           logic [31:0] old);
        logic [31:0] vlmax;
        vlmax = 64 / (8 << s);
        if (rs1_nz)
            return (avl < vlmax) ? avl : vlmax;
        if (rd_nz)
            return vlmax;
        return old;                    // x0, x0 keeps vl
    endfunction

    function automatic logic [7:0] ref_be(sew_e s, logic [31:0] vl);
        logic [31:0] nbytes;
        nbytes = vl * (32'd1 << s);    // bytes held by the active elements
        if (nbytes >= 8)
            return 8'hff;
        return 8'hff >> (32'd8 - nbytes);
    endfunction

    function automatic logic [5:0] funct6_of(alu_op_e op);
        case (op)
            alu_add: return f6_add;
            alu_sub: return f6_sub;
            alu_and: return f6_and;
            alu_or:  return f6_or;
            default: return f6_xor;
        endcase
    endfunction

    function automatic insn_u enc_opv(logic [5:0] f6, logic [4:0] v2, logic [4:0] s1,
                                      logic [2:0] f3, logic [4:0] d);
        insn_u w;
        w.arith_v = '{funct6: f6, vm: 1'b1, vs2: v2, src1: s1, funct3: f3, vd: d,
                      opcode: opc_opv};
        return w;
    endfunction

    function automatic insn_u enc_cfg(sew_e s, logic [4:0] r1, logic [4:0] d);
        insn_u w;
        w.cfg_v = '{top: 1'b0, vtypei: {6'd0, s, 3'd0}, rs1: r1, funct3: f3_cfg, rd: d,
                    opcode: opc_opv};
        return w;
    endfunction

    function automatic insn_u enc_store(logic [4:0] v3);
        insn_u w;
        w.store_v = '{nf: 3'd0, mew: 1'b0, mop: 2'b00, vm: 1'b1, sumop: 5'h08, rs1: 5'd10,
                      width: 3'b000, vs3: v3, opcode: opc_store};
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("timeout at %0t ns: %s", $time, why);
        $display("TEST FAILED");
        $finish;
    endtask

    // called at a falling edge, returns at the falling edge after acceptance
    task automatic send(input insn_u w, input logic [xlen-1:0] s);
        int waited;
        waited     = 0;
        insn_in    = w;
        scalar_in  = s;
        insn_valid = 1'b1;
        while (!proc_rdy && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!proc_rdy) begin
            abort_run("proc_rdy stayed low for 100 cycles");
        end else begin
            @(negedge clk);
            insn_valid = 1'b0;
        end
    endtask

    task automatic do_vset(input sew_e s, input logic [4:0] r1, input logic [4:0] d,
                           input logic [31:0] avl);
        model_vl  = ref_vl(r1 != 0, d != 0, avl, s, model_vl);
        model_sew = s;
        exp_vl.push_back(model_vl);
        n_exp++;
        send(enc_cfg(s, r1, d), avl);
    endtask

    task automatic do_alu(input alu_op_e op, input logic [2:0] f3, input logic [4:0] d,
                          input logic [4:0] v2, input logic [4:0] s1, input logic [31:0] x);
        logic [63:0] a;
        logic [63:0] res;
        logic [63:0] m;
        logic [7:0]  be;
        int          i;
        case (f3)
            f3_ivi:  a = ref_splat(model_sew, {{59{s1[4]}}, s1});
            f3_ivx:  a = ref_splat(model_sew, {{32{x[31]}}, x});
            default: a = model_regs[s1];
        endcase
        res = ref_alu(op, model_sew, a, model_regs[v2]);
        be  = ref_be(model_sew, model_vl);
        for (i = 0; i < 8; i++)
            m[i*8 +: 8] = {8{be[i]}};
        model_regs[d] = (model_regs[d] & ~m) | (res & m);   // tail undisturbed
        send(enc_opv(funct6_of(op), v2, s1, f3, d), x);
    endtask

    task automatic do_store(input logic [4:0] v3, input logic [31:0] base);
        exp_store.push_back('{addr: base, data: model_regs[v3],
                              be: ref_be(model_sew, model_vl)});
        n_exp++;
        send(enc_store(v3), base);
    endtask

    task automatic check_store(input store_t exp, input store_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns mem_out exp=%h got=%h", $time, exp, got);
        end
    endtask

    task automatic check_vl(input logic [xlen-1:0] exp, input logic [xlen-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns scalar_out exp=%0d got=%0d", $time, exp, got);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_store.size() != 0 || exp_vl.size() != 0) && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        if (exp_store.size() != 0 || exp_vl.size() != 0)
            abort_run("expected results never arrived within 500 cycles");
        else
            repeat (6) @(negedge clk);    // room for any stray output
    endtask

    task automatic end_test(input string name);
        drain();
        $display("%s: %s, %0d errors", name, (errors == err0) ? "ok" : "mismatch",
                 errors - err0);
        err0 = errors;
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (rst_n && mem_valid) begin
            n_got++;
            if (exp_store.size() == 0) begin
                errors++;
                $display("store appeared at %0t ns with none expected", $time);
            end else begin
                check_store(exp_store.pop_front(), mem_out);
            end
        end
        if (rst_n && scalar_valid) begin
            n_got++;
            if (exp_vl.size() == 0) begin
                errors++;
                $display("vl result appeared at %0t ns with none expected", $time);
            end else begin
                check_vl(exp_vl.pop_front(), scalar_out);
            end
        end
    end

    initial begin
        int          k;
        int          pick;
        logic [31:0] avls [3];
        logic [2:0]  f3s [3];
        rst_n      = 1'b0;
        insn_in    = '0;
        insn_valid = 1'b0;
        scalar_in  = '0;
        seed       = 32'h601b_f7b9;
        errors     = 0;
        checks     = 0;
        n_exp      = 0;
        n_got      = 0;
        err0       = 0;
        model_vl   = '0;
        model_sew  = e8;
        avls       = '{32'd0, 32'd3, 32'd20};
        f3s        = '{f3_ivv, f3_ivi, f3_ivx};
        for (k = 0; k < num_vec; k++)
            model_regs[k] = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // vsetvli across all sews and avls, then the x0 forms
        if (!proc_rdy) begin
            errors++;
            $display("proc_rdy was low right after reset");
        end
        for (k = 0; k < 12; k++)
            do_vset(sew_e'(k / 3), 5'd5, 5'd1, avls[k % 3]);
        do_vset(e16, 5'd0, 5'd1, 32'd2);     // vlmax, avl ignored
        do_vset(e8, 5'd0, 5'd0, 32'd7);      // vl kept
        end_test("vsetvli");

        for (k = 0; k < 4; k++) begin
            do_vset(sew_e'(k), 5'd5, 5'd1, 32'd20);
            do_alu(alu_add, f3_ivx, 5'd1, 5'd0, 5'd3, $random(seed));
            do_store(5'd1, $random(seed));
            do_alu(alu_add, f3_ivi, 5'd2, 5'd0, 5'h1b, 32'd0);   // simm5 of -5
            do_store(5'd2, $random(seed));
        end
        end_test("splat");

        // dependent chain, each op waits on the one before
        for (k = 0; k < 4; k++) begin
            do_vset(sew_e'(k), 5'd5, 5'd1, 32'd20);
            do_alu(alu_add, f3_ivx, 5'd1, 5'd0, 5'd0, $random(seed));
            do_alu(alu_add, f3_ivi, 5'd2, 5'd1, 5'd9, 32'd0);
            do_alu(alu_add, f3_ivv, 5'd3, 5'd1, 5'd2, 32'd0);
            do_alu(alu_sub, f3_ivv, 5'd4, 5'd3, 5'd1, 32'd0);
            do_alu(alu_and, f3_ivv, 5'd5, 5'd4, 5'd3, 32'd0);
            do_alu(alu_or, f3_ivv, 5'd6, 5'd5, 5'd2, 32'd0);
            do_alu(alu_xor, f3_ivv, 5'd7, 5'd6, 5'd4, 32'd0);
            do_store(5'd7, 32'h1000 + k);
            do_store(5'd4, 32'h2000 + k);
        end
        end_test("dependent chain");

        do_vset(e16, 5'd5, 5'd1, 32'd2);
        do_alu(alu_add, f3_ivi, 5'd1, 5'd2, 5'd3, 32'd0);    // lanes 2 and 3 keep v1
        do_store(5'd1, 32'h3000);
        do_vset(e8, 5'd5, 5'd1, 32'd3);
        do_alu(alu_xor, f3_ivx, 5'd2, 5'd1, 5'd0, $random(seed));
        do_store(5'd2, 32'h3008);
        end_test("tail undisturbed");

        do_vset(e32, 5'd5, 5'd1, 32'd20);
        send(enc_opv(f6_add, 5'd1, 5'd2, 3'd1, 5'd4), 32'd0);       // opfvv
        send(enc_opv(6'b111111, 5'd1, 5'd2, f3_ivv, 5'd4), 32'd0);  // no such funct6
        do_alu(alu_sub, f3_ivv, 5'd3, 5'd1, 5'd2, 32'd0);
        do_store(5'd3, 32'h4000);
        do_store(5'd4, 32'h4008);    // v4 must still hold the chain result
        end_test("unsupported");

        exp0 = n_exp;
        got0 = n_got;
        for (k = 0; k < 200; k++) begin
            pick = $unsigned($random(seed)) % 10;
            if (pick < 2)
                do_vset(sew_e'($unsigned($random(seed)) % 4),
                        5'($unsigned($random(seed)) % 3), 5'($unsigned($random(seed)) % 2),
                        $unsigned($random(seed)) % 12);
            else if (pick < 4)
                do_store(5'($unsigned($random(seed)) % 8), $random(seed));
            else
                do_alu(alu_op_e'($unsigned($random(seed)) % 5),
                       f3s[$unsigned($random(seed)) % 3], 5'($unsigned($random(seed)) % 8),
                       5'($unsigned($random(seed)) % 8), 5'($unsigned($random(seed)) % 8),
                       $random(seed));
        end
        drain();
        if (n_got - got0 != n_exp - exp0) begin
            errors++;
            $display("ERROR %0t ns result_count exp=%0d got=%0d", $time, n_exp - exp0,
                     n_got - got0);
        end
        end_test("random");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: logic/rvv_core.sv
`timescale 1ns/100ps

module rvv_core (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rvv_pkg::insn_u           insn_in,
    input  logic                     insn_valid,
    input  logic [rvv_pkg::xlen-1:0] scalar_in,
    output logic                     proc_rdy,
    output logic                     mem_valid,
    output rvv_pkg::store_t          mem_out,
    output logic                     scalar_valid,
    output logic [rvv_pkg::xlen-1:0] scalar_out
);
    import rvv_pkg::*;

    insn_u                 fetch_insn;
    decoded_t              dec;
    decoded_t              cfg_dec;
    logic [reg_addr_w-1:0] rd_addr_1;
    logic [reg_addr_w-1:0] rd_addr_2;
    logic [data_w-1:0]     rd_data_1;
    logic [data_w-1:0]     rd_data_2;
    sew_e                  sew;
    logic [dw_b-1:0]       tail_be;
    logic                  cfg_we;
    logic [xlen-1:0]       cfg_avl;
    alu_req_t              alu_req;     // raw operands at issue
    alu_req_t              alu_req_q;   // operands after the splat stage
    wb_t                   wb;

    issue_ctrl issue_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .insn_in      (insn_in),
        .insn_valid   (insn_valid),
        .scalar_in    (scalar_in),
        .proc_rdy     (proc_rdy),
        .fetch_insn   (fetch_insn),
        .dec          (dec),
        .rd_addr_1    (rd_addr_1),
        .rd_addr_2    (rd_addr_2),
        .rd_data_1    (rd_data_1),
        .rd_data_2    (rd_data_2),
        .sew          (sew),
        .tail_be      (tail_be),
        .cfg_we       (cfg_we),
        .cfg_dec      (cfg_dec),
        .cfg_avl      (cfg_avl),
        .alu_req      (alu_req),
        .wb           (wb),
        .mem_valid    (mem_valid),
        .mem_out      (mem_out),
        .scalar_valid (scalar_valid)
    );

    insn_decoder insn_decoder_inst (
        .insn (fetch_insn),
        .dec  (dec)
    );

    cfg_unit cfg_unit_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_we  (cfg_we),
        .dec     (cfg_dec),
        .avl     (cfg_avl),
        .sew     (sew),
        .vl      (scalar_out),   // vl goes straight back to the scalar side
        .tail_be (tail_be)
    );

    vec_regfile vec_regfile_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_1 (rd_addr_1),
        .rd_addr_2 (rd_addr_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .wb        (wb)
    );

    operand_mux operand_mux_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_in  (alu_req),
        .scalar  (cfg_avl),       // fetched rs1 value
        .imm     (dec.imm),
        .form    (dec.form),
        .req_out (alu_req_q)
    );

    simd_alu simd_alu_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (alu_req_q),
        .wb    (wb)
    );

endmodule

// File: valu/simd_alu.sv
`timescale 1ns/100ps

module simd_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  rvv_pkg::alu_req_t req,
    output rvv_pkg::wb_t      wb
);
    import rvv_pkg::*;

    logic [data_w-1:0] arith [4];   // add/sub result for each sew
    logic [data_w-1:0] result;

    // lanes at 8, 16, 32 and 64 bits; carries stop at lane edges
    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int ew = 8 << s;
        for (genvar e = 0; e < data_w / ew; e++) begin : g_lane
            assign arith[s][e*ew +: ew] = (req.op == alu_sub)
                                        ? req.b[e*ew +: ew] - req.a[e*ew +: ew]  // vs2 - a
                                        : req.b[e*ew +: ew] + req.a[e*ew +: ew];
        end
    end

    always_comb begin
        case (req.op)
            alu_and: result = req.b & req.a;   // bitwise ops ignore sew
            alu_or:  result = req.b | req.a;
            alu_xor: result = req.b ^ req.a;
            default: result = arith[req.sew];
        endcase
    end

    always_ff @(posedge clk) begin
        wb <= '{valid: req.valid, addr: req.vd, data: result, be: req.be};
        if (!rst_n)
            wb.valid <= 1'b0;
    end

    wb_follow_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid == $past(req.valid)) else $error("writeback out of step with request");

endmodule

// File: valu/operand_mux.sv
`timescale 1ns/100ps

module operand_mux (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rvv_pkg::alu_req_t        req_in,
    input  logic [rvv_pkg::xlen-1:0] scalar,
    input  logic [4:0]               imm,
    input  logic [1:0]               form,
    output rvv_pkg::alu_req_t        req_out
);
    import rvv_pkg::*;

    logic [data_w-1:0] ext;     // scalar or simm5, sign extended to 64
    logic [data_w-1:0] splat;   // ext copied into every lane
    alu_req_t          nxt;

    assign ext = (form == form_vi) ? {{(data_w-5){imm[4]}}, imm}
                                   : {{(data_w-xlen){scalar[xlen-1]}}, scalar};

    always_comb begin
        case (req_in.sew)
            e8:      splat = {dw_b{ext[7:0]}};
            e16:     splat = {(dw_b/2){ext[15:0]}};
            e32:     splat = {(dw_b/4){ext[31:0]}};
            default: splat = ext;
        endcase
        nxt = req_in;
        if (form != form_vv)
            nxt.a = splat;        // vv keeps vs1 from the read port
    end

    // stage 1, request leaves here on the issue edge
    always_ff @(posedge clk) begin
        req_out <= nxt;
        if (!rst_n)
            req_out.valid <= 1'b0;
    end

endmodule

// File: logic/vec_regfile.sv
`timescale 1ns/100ps

module vec_regfile (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [rvv_pkg::reg_addr_w-1:0] rd_addr_1,
    input  logic [rvv_pkg::reg_addr_w-1:0] rd_addr_2,
    output logic [rvv_pkg::data_w-1:0]     rd_data_1,
    output logic [rvv_pkg::data_w-1:0]     rd_data_2,
    input  rvv_pkg::wb_t                   wb
);
    import rvv_pkg::*;

    logic [data_w-1:0] regs [num_vec];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < num_vec; r++)
                regs[r] <= '0;             // v0..v31 start at zero
        end else if (wb.valid) begin
            // masked-off tail bytes keep their old value
            for (int b = 0; b < dw_b; b++) begin
                if (wb.be[b])
                    regs[wb.addr][b*8 +: 8] <= wb.data[b*8 +: 8];
            end
        end
    end

    assign rd_data_1 = regs[rd_addr_1];
    assign rd_data_2 = regs[rd_addr_2];

endmodule

// File: logic/cfg_unit.sv
`timescale 1ns/100ps

module cfg_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_we,
    input  rvv_pkg::decoded_t        dec,
    input  logic [rvv_pkg::xlen-1:0] avl,
    output rvv_pkg::sew_e            sew,
    output logic [rvv_pkg::xlen-1:0] vl,
    output logic [rvv_pkg::dw_b-1:0] tail_be
);
    import rvv_pkg::*;

    logic [xlen-1:0] vlmax;   // elements per register at the new sew

    assign vlmax = xlen'(dw_b) >> dec.sew;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sew <= e8;
            vl  <= '0;
        end else if (cfg_we) begin
            sew <= dec.sew;
            if (dec.rs1_nz)
                vl <= (avl < vlmax) ? avl : vlmax;
            else if (dec.rd_nz)
                vl <= vlmax;      // rs1 = x0, rd != x0 asks for vlmax
        end
    end

    // byte i belongs to element i >> sew
    always_comb begin
        for (int i = 0; i < dw_b; i++)
            tail_be[i] = xlen'(i >> sew) < vl;
    end

    vl_max_a: assert property (@(posedge clk) disable iff (!rst_n)
        vl <= xlen'(dw_b)) else $error("vl beyond one register");

endmodule

// File: logic/issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  rvv_pkg::insn_u                  insn_in,
    input  logic                            insn_valid,
    input  logic [rvv_pkg::xlen-1:0]        scalar_in,
    output logic                            proc_rdy,
    output rvv_pkg::insn_u                  fetch_insn,
    input  rvv_pkg::decoded_t               dec,
    output logic [rvv_pkg::reg_addr_w-1:0]  rd_addr_1,
    output logic [rvv_pkg::reg_addr_w-1:0]  rd_addr_2,
    input  logic [rvv_pkg::data_w-1:0]      rd_data_1,
    input  logic [rvv_pkg::data_w-1:0]      rd_data_2,
    input  rvv_pkg::sew_e                   sew,
    input  logic [rvv_pkg::dw_b-1:0]        tail_be,
    output logic                            cfg_we,
    output rvv_pkg::decoded_t               cfg_dec,
    output logic [rvv_pkg::xlen-1:0]        cfg_avl,
    output rvv_pkg::alu_req_t               alu_req,
    input  rvv_pkg::wb_t                    wb,
    output logic                            mem_valid,
    output rvv_pkg::store_t                 mem_out,
    output logic                            scalar_valid
);
    import rvv_pkg::*;

    logic               fetch_vld;
    logic [xlen-1:0]    fetch_scalar;   // rs1 value held with the word
    logic [num_vec-1:0] pending;        // vd of an alu op still in flight
    logic [num_vec-1:0] set_vec;
    logic [num_vec-1:0] clr_vec;
    logic               use_vs1;
    logic               use_vs2;
    logic               use_vs3;
    logic               stall;
    logic               issue;

    assign use_vs1 = dec.kind == k_alu && dec.form == form_vv;
    assign use_vs2 = dec.kind == k_alu;    // also marks vd as written
    assign use_vs3 = dec.kind == k_store;

    // raw and waw on the scoreboard; stores also keep mem_valid a single pulse
    assign stall = fetch_vld && ((use_vs1 && pending[dec.vs1]) ||
                                 (use_vs2 && (pending[dec.vs2] || pending[dec.vd])) ||
                                 (use_vs3 && (pending[dec.vs3] || mem_valid)));
    assign issue    = fetch_vld && !stall;
    assign proc_rdy = !fetch_vld || issue;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_vld <= 1'b0;
        end else if (proc_rdy) begin
            fetch_vld <= insn_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (proc_rdy && insn_valid) begin
            fetch_insn   <= insn_in;
            fetch_scalar <= scalar_in;
        end
    end

    // scoreboard, set on alu issue and cleared by writeback
    assign set_vec = (issue && use_vs2) ? (num_vec'(1) << dec.vd) : '0;
    assign clr_vec = wb.valid ? (num_vec'(1) << wb.addr) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_vec) | set_vec;
        end
    end

    assign rd_addr_1 = use_vs3 ? dec.vs3 : dec.vs1;    // store data shares port 1
    assign rd_addr_2 = dec.vs2;

    always_comb begin
        alu_req.valid = issue && use_vs2;
        alu_req.op    = dec.alu_op;
        alu_req.sew   = sew;
        alu_req.vd    = dec.vd;
        alu_req.a     = rd_data_1;    // replaced by the splat for vx/vi
        alu_req.b     = rd_data_2;
        alu_req.be    = tail_be;
    end

    assign cfg_we  = issue && dec.kind == k_cfg;
    assign cfg_dec = dec;
    assign cfg_avl = fetch_scalar;    // avl for vsetvli, scalar operand for vx

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid    <= 1'b0;
            scalar_valid <= 1'b0;
        end else begin
            mem_valid    <= issue && use_vs3;
            scalar_valid <= cfg_we;   // vl is already updated by then
        end
    end

    always_ff @(posedge clk) begin
        if (issue && use_vs3)
            mem_out <= '{addr: fetch_scalar, data: rd_data_1, be: tail_be};
    end

    // writeback must land on a register the scoreboard still tracks
    wb_pending_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid |-> pending[wb.addr]) else $error("writeback to idle register");

    mem_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid |=> !mem_valid) else $error("mem_valid held two cycles");

endmodule

// File: logic/insn_decoder.sv
`timescale 1ns/100ps

module insn_decoder (
    input  rvv_pkg::insn_u    insn,
    output rvv_pkg::decoded_t dec
);
    import rvv_pkg::*;

    logic [2:0] f3;
    logic       op_ok;   // funct6 is one we implement

    assign f3 = insn.arith_v.funct3;

    always_comb begin
        dec        = '0;                        // kind none unless matched below
        dec.vd     = insn.arith_v.vd;
        dec.vs1    = insn.arith_v.src1;
        dec.vs2    = insn.arith_v.vs2;
        dec.vs3    = insn.store_v.vs3;
        dec.imm    = insn.arith_v.src1;         // simm5 sits in the vs1 slot
        dec.sew    = sew_e'(insn.cfg_v.vtypei[4:3]);   // vsew, low two bits
        dec.rd_nz  = |insn.cfg_v.rd;
        dec.rs1_nz = |insn.cfg_v.rs1;

        op_ok = 1'b1;
        case (insn.arith_v.funct6)
            f6_add:  dec.alu_op = alu_add;
            f6_sub:  dec.alu_op = alu_sub;
            f6_and:  dec.alu_op = alu_and;
            f6_or:   dec.alu_op = alu_or;
            f6_xor:  dec.alu_op = alu_xor;
            default: op_ok = 1'b0;
        endcase

        case (f3)
            f3_ivi:  dec.form = form_vi;
            f3_ivx:  dec.form = form_vx;
            default: dec.form = form_vv;
        endcase

        if (insn.arith_v.opcode == opc_opv) begin
            if (f3 == f3_cfg) begin
                if (!insn.cfg_v.top)
                    dec.kind = k_cfg;           // vsetivli/vsetvl fall to none
            end else if ((f3 == f3_ivv || f3 == f3_ivi || f3 == f3_ivx) && op_ok) begin
                dec.kind = k_alu;               // float and mvv/mvx stay none
            end
        end else if (insn.store_v.opcode == opc_store) begin
            // unit stride only, plain or whole-register form
            if (insn.store_v.mop == 2'b00 && !insn.store_v.mew && insn.store_v.nf == 3'd0 &&
                (insn.store_v.sumop == 5'h00 || insn.store_v.sumop == 5'h08))
                dec.kind = k_store;
        end
    end

endmodule

// File: common/rvv_pkg.sv
package rvv_pkg;

    localparam int data_w     = 64;            // datapath width, equal to VLEN
    localparam int dw_b       = data_w / 8;    // bytes per register
    localparam int num_vec    = 32;
    localparam int reg_addr_w = 5;
    localparam int xlen       = 32;            // scalar side width

    // major opcodes
    localparam logic [6:0] opc_store = 7'h27;
    localparam logic [6:0] opc_opv   = 7'h57;

    // minor opcodes, OP-V funct3
    localparam logic [2:0] f3_ivv = 3'd0;
    localparam logic [2:0] f3_ivi = 3'd3;
    localparam logic [2:0] f3_ivx = 3'd4;
    localparam logic [2:0] f3_cfg = 3'd7;

    // integer funct6 codes kept from the full OPI table
    localparam logic [5:0] f6_add = 6'b000000;
    localparam logic [5:0] f6_sub = 6'b000010;
    localparam logic [5:0] f6_and = 6'b001001;
    localparam logic [5:0] f6_or  = 6'b001010;
    localparam logic [5:0] f6_xor = 6'b001011;

    // operand a source
    localparam logic [1:0] form_vv = 2'd0;
    localparam logic [1:0] form_vi = 2'd1;
    localparam logic [1:0] form_vx = 2'd2;

    typedef enum logic [1:0] {e8, e16, e32, e64} sew_e;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_e;

    typedef enum logic [1:0] {k_none, k_alu, k_store, k_cfg} insn_kind_e;

    // one fetched word, read through the view that opcode/funct3 pick
    typedef union packed {
        struct packed {
            logic [5:0] funct6;
            logic       vm;
            logic [4:0] vs2;
            logic [4:0] src1;      // vs1, rs1 or simm5
            logic [2:0] funct3;
            logic [4:0] vd;
            logic [6:0] opcode;
        } arith_v;
        struct packed {
            logic [2:0] nf;
            logic       mew;
            logic [1:0] mop;
            logic       vm;
            logic [4:0] sumop;
            logic [4:0] rs1;       // base address register
            logic [2:0] width;
            logic [4:0] vs3;
            logic [6:0] opcode;
        } store_v;
        struct packed {
            logic        top;       // 0 selects vsetvli
            logic [10:0] vtypei;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } cfg_v;
    } insn_u;

    typedef struct packed {
        insn_kind_e kind;
        alu_op_e    alu_op;
        logic [1:0] form;
        logic [4:0] vd;
        logic [4:0] vs1;
        logic [4:0] vs2;
        logic [4:0] vs3;
        logic [4:0] imm;
        sew_e       sew;            // vsetvli target sew
        logic       rd_nz;
        logic       rs1_nz;
    } decoded_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               op;
        sew_e                  sew;
        logic [reg_addr_w-1:0] vd;
        logic [data_w-1:0]     a;
        logic [data_w-1:0]     b;   // always vs2
        logic [dw_b-1:0]       be;  // tail byte enable
    } alu_req_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] addr;
        logic [data_w-1:0]     data;
        logic [dw_b-1:0]       be;
    } wb_t;

    typedef struct packed {
        logic [xlen-1:0]   addr;
        logic [data_w-1:0] data;
        logic [dw_b-1:0]   be;
    } store_t;

endpackage
